/* agc_bank_map_pkg.sv */
// Bank translation types and constants
// Word, address and bank formats of the 15-bit guidance computer, the memory
// region map, the bank register selector and the translation structs

package agc_bank_map_pkg;

  // Machine formats
  typedef logic [14:0] word_t;
  typedef logic [11:0] soft_addr_t;
  typedef logic [13:0] rom_addr_t;
  typedef logic [10:0] ram_addr_t;
  typedef logic [2:0]  bank_t;

  // Software address map
  localparam soft_addr_t ROM_REGION_BASE = 12'o2000;
  localparam soft_addr_t FIXED_ROM_BASE  = 12'o4000;
  localparam soft_addr_t RAM_BANKED_BASE = 12'o1400;

  // Bank geometry in physical memory
  localparam rom_addr_t ROM_BANK_SIZE   = 14'o02000;
  localparam ram_addr_t RAM_BANK_SIZE   = 11'o0400;
  localparam ram_addr_t RAM_HIGH_OFFSET = 11'o2000;

  // Field positions inside the BB word
  localparam int unsigned EB_LSB = 9;
  localparam int unsigned FB_LSB = 12;

  // Wishbone register select, code 3 reads zero
  typedef enum logic [1:0] {
    BANK_EB = 2'd0,
    BANK_FB = 2'd1,
    BANK_BB = 2'd2
  } bank_sel_t;

  typedef struct packed {
    bank_t eb;
    bank_t fb;
  } bank_state_t;

  typedef struct packed {
    soft_addr_t fetch_addr;
    soft_addr_t read_addr;
    soft_addr_t write_addr;
    logic       write_en;
  } xlate_req_t;

  typedef struct packed {
    rom_addr_t fetch_rom;
    rom_addr_t read_rom;
    ram_addr_t read_ram;
    logic      read_is_rom;
    ram_addr_t write_ram;
    logic      write_en;
  } xlate_rsp_t;

endpackage

/* bank_regs_wb.sv */
// Bank register file behind a Wishbone classic slave
// Holds the erasable and fixed bank numbers, takes partial-field writes by
// selector and returns the fields in their BB word positions

`timescale 1ns/1ps

module bank_regs_wb
  import agc_bank_map_pkg::*;
(
  input  logic        clk,
  input  logic        rst_l,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  bank_sel_t   wb_adr,
  input  word_t       wb_wdata,
  output word_t       wb_rdata,
  output logic        wb_ack,
  output bank_state_t bank
);

  logic  access;
  word_t rd_word;
  bank_t wr_eb;
  bank_t wr_fb;

  // New transfer seen, ack not yet given
  assign access = wb_cyc & wb_stb & ~wb_ack;

  assign wr_eb = wb_wdata[EB_LSB +: $bits(bank_t)];
  assign wr_fb = wb_wdata[FB_LSB +: $bits(bank_t)];

  // Readback formatting, each selector shows only its own field
  always_comb begin
    rd_word = '0;
    case (wb_adr)
      BANK_EB: begin
        rd_word[EB_LSB +: $bits(bank_t)] = bank.eb;
      end
      BANK_FB: begin
        rd_word[FB_LSB +: $bits(bank_t)] = bank.fb;
      end
      BANK_BB: begin
        rd_word[EB_LSB +: $bits(bank_t)] = bank.eb;
        rd_word[FB_LSB +: $bits(bank_t)] = bank.fb;
      end
      default: begin
        rd_word = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      wb_ack <= 1'b0;
      bank   <= '0;
    end else begin
      wb_ack <= access;
      if (access && wb_we) begin
        case (wb_adr)
          BANK_EB: bank.eb <= wr_eb;
          BANK_FB: bank.fb <= wr_fb;
          BANK_BB: begin
            bank.eb <= wr_eb;
            bank.fb <= wr_fb;
          end
          default: begin
            // Unmapped select, write dropped
            bank <= bank;
          end
        endcase
      end
    end
  end

  // Read data captured with the ack edge, held while ack is high
  always_ff @(posedge clk) begin
    if (access) begin
      wb_rdata <= rd_word;
    end
  end

endmodule

/* rom_bank_map.sv */
// Fixed memory address translation
// Maps a software address to a physical ROM address, either the fixed-fixed
// area or the bank selected by FB

`timescale 1ns/1ps

module rom_bank_map
  import agc_bank_map_pkg::*;
(
  input  soft_addr_t addr,
  input  bank_t      fb,
  output rom_addr_t  rom_addr
);

  logic      is_fixed;
  rom_addr_t bank_offset;
  rom_addr_t banked_addr;

  assign is_fixed = (addr >= FIXED_ROM_BASE);

  // Bank base lookup, avoids a multiplier
  always_comb begin
    case (fb)
      3'd0:    bank_offset = 14'o00000;
      3'd1:    bank_offset = 14'o02000;
      3'd2:    bank_offset = 14'o04000;
      3'd3:    bank_offset = 14'o06000;
      3'd4:    bank_offset = 14'o10000;
      3'd5:    bank_offset = 14'o12000;
      3'd6:    bank_offset = 14'o14000;
      default: bank_offset = 14'o16000;
    endcase
  end

  // Banked window starts one bank above the fixed-fixed area
  assign banked_addr = {2'b00, addr} + ROM_BANK_SIZE + bank_offset;

  assign rom_addr = is_fixed ? {2'b00, addr - FIXED_ROM_BASE} : banked_addr;

endmodule

/* ram_bank_map.sv */
// Erasable memory address translation
// Maps a software address to a physical RAM address, passing the fixed area
// through and offsetting the banked window by EB

`timescale 1ns/1ps

module ram_bank_map
  import agc_bank_map_pkg::*;
(
  input  soft_addr_t addr,
  input  bank_t      eb,
  output ram_addr_t  ram_addr
);

  logic      is_fixed;
  ram_addr_t low_offset;
  ram_addr_t bank_offset;

  assign is_fixed = (addr < RAM_BANKED_BASE);

  // Low banks from EB bits 1..0
  always_comb begin
    case (eb[1:0])
      2'd0:    low_offset = '0;
      2'd1:    low_offset = RAM_BANK_SIZE;
      2'd2:    low_offset = RAM_BANK_SIZE << 1;
      default: low_offset = (RAM_BANK_SIZE << 1) + RAM_BANK_SIZE;
    endcase
  end

  // EB bit 2 overrides the low bank select
  assign bank_offset = eb[2] ? RAM_HIGH_OFFSET : low_offset;

  assign ram_addr = is_fixed ? addr[10:0] : addr[10:0] + bank_offset;

endmodule

/* access_resolve.sv */
// Translation response stage
// Picks the ROM or RAM result for the read port, blocks writes into ROM and
// registers the combined response with its valid flag

`timescale 1ns/1ps

module access_resolve
  import agc_bank_map_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,
  input  logic       req_valid,
  input  xlate_req_t req,
  input  rom_addr_t  fetch_rom,
  input  rom_addr_t  read_rom,
  input  ram_addr_t  read_ram,
  input  ram_addr_t  write_ram,
  output logic       rsp_valid,
  output xlate_rsp_t rsp
);

  logic       read_in_rom;
  logic       write_in_ram;
  xlate_rsp_t rsp_next;

  assign read_in_rom  = (req.read_addr >= ROM_REGION_BASE);
  assign write_in_ram = (req.write_addr < ROM_REGION_BASE);

  always_comb begin
    rsp_next.fetch_rom   = fetch_rom;
    rsp_next.read_is_rom = read_in_rom;

    // Idle read port gets the lowest valid address of its memory
    if (read_in_rom) begin
      rsp_next.read_rom = read_rom;
      rsp_next.read_ram = '0;
    end else begin
      rsp_next.read_rom = {2'b00, ROM_REGION_BASE};
      rsp_next.read_ram = read_ram;
    end

    // RAM address always passed, enable only for the erasable region
    rsp_next.write_ram = write_ram;
    rsp_next.write_en  = req.write_en & write_in_ram;
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid) begin
      rsp <= rsp_next;
    end
  end

endmodule

/* agc_bank_map.sv */
// Memory bank translation unit
// Bank registers on a Wishbone port plus fetch, read and write address
// translation with one registered output stage

`timescale 1ns/1ps

module agc_bank_map
  import agc_bank_map_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  bank_sel_t  wb_adr,
  input  word_t      wb_wdata,
  output word_t      wb_rdata,
  output logic       wb_ack,
  input  logic       req_valid,
  input  xlate_req_t req,
  output logic       rsp_valid,
  output xlate_rsp_t rsp
);

  bank_state_t bank;
  rom_addr_t   fetch_rom_addr;
  rom_addr_t   read_rom_addr;
  ram_addr_t   read_ram_addr;
  ram_addr_t   write_ram_addr;

  bank_regs_wb bank_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .bank     (bank)
  );

  // Instruction fetch always lands in ROM
  rom_bank_map fetch_rom (
    .addr     (req.fetch_addr),
    .fb       (bank.fb),
    .rom_addr (fetch_rom_addr)
  );

  // Data read translated both ways, resolver picks one
  rom_bank_map read_rom (
    .addr     (req.read_addr),
    .fb       (bank.fb),
    .rom_addr (read_rom_addr)
  );

  ram_bank_map read_ram (
    .addr     (req.read_addr),
    .eb       (bank.eb),
    .ram_addr (read_ram_addr)
  );

  ram_bank_map write_ram (
    .addr     (req.write_addr),
    .eb       (bank.eb),
    .ram_addr (write_ram_addr)
  );

  access_resolve resolve (
    .clk       (clk),
    .rst_l     (rst_l),
    .req_valid (req_valid),
    .req       (req),
    .fetch_rom (fetch_rom_addr),
    .read_rom  (read_rom_addr),
    .read_ram  (read_ram_addr),
    .write_ram (write_ram_addr),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule

/* tb_agc_bank_map.sv */
// Testbench for the memory bank translation unit
// Directed tests of the bank register port and the fetch, read and write
// translation against a reference model of the address map

`timescale 1ns/1ps

module tb_agc_bank_map
  import agc_bank_map_pkg::*;
();

  localparam int MAX_CYCLES = 5000;

  logic        clk;
  logic        rst_l;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  bank_sel_t   wb_adr;
  word_t       wb_wdata;
  word_t       wb_rdata;
  logic        wb_ack;
  logic        req_valid;
  xlate_req_t  req;
  logic        rsp_valid;
  xlate_rsp_t  rsp;

  // Bank values as the DUT should hold them
  bank_t       eb_model;
  bank_t       fb_model;

  int          errors;
  int          checks;
  int          cycle_count = 0;
  logic [31:0] rand_state;

  soft_addr_t  read_edges [4] = '{12'o1377, 12'o1400, 12'o1777, 12'o2000};
  soft_addr_t  write_edges [6] = '{12'o0000, 12'o1377, 12'o1400, 12'o1777,
                                   12'o2000, 12'o7777};
  bank_t       gate_banks [4] = '{3'd0, 3'd3, 3'd4, 3'd6};

  agc_bank_map agc_bank_map_inst (
    .clk       (clk),
    .rst_l     (rst_l),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_wdata  (wb_wdata),
    .wb_rdata  (wb_rdata),
    .wb_ack    (wb_ack),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  function automatic soft_addr_t addr_in_range(input int unsigned lo, input int unsigned span);
    int unsigned v;
    v = lo + (next_random() % span);
    return soft_addr_t'(v);
  endfunction

  function automatic xlate_req_t random_request();
    xlate_req_t r;
    r.fetch_addr = addr_in_range(0, 'o10000);
    r.read_addr  = addr_in_range(0, 'o10000);
    r.write_addr = addr_in_range(0, 'o10000);
    r.write_en   = next_random() % 2 == 1;
    return r;
  endfunction

  // Reference address map
  function automatic rom_addr_t rom_model(input soft_addr_t addr, input bank_t fb);
    int unsigned sum;
    if (addr >= 12'o4000) begin
      sum = addr - 'o4000;
    end else begin
      sum = addr + 'o2000 + fb * 'o2000;
    end
    return rom_addr_t'(sum);
  endfunction

  function automatic ram_addr_t ram_model(input soft_addr_t addr, input bank_t eb);
    int unsigned offset;
    int unsigned sum;
    if (addr < 12'o1400) begin
      return addr[10:0];
    end
    offset = eb[2] ? 'o2000 : eb[1:0] * 'o400;
    sum    = addr[10:0] + offset;
    return ram_addr_t'(sum);
  endfunction

  function automatic xlate_rsp_t expected_rsp(input xlate_req_t r);
    xlate_rsp_t e;
    e.fetch_rom = rom_model(r.fetch_addr, fb_model);
    if (r.read_addr >= 12'o2000) begin
      e.read_is_rom = 1'b1;
      e.read_rom    = rom_model(r.read_addr, fb_model);
      e.read_ram    = '0;
    end else begin
      e.read_is_rom = 1'b0;
      e.read_rom    = 14'o02000;
      e.read_ram    = ram_model(r.read_addr, eb_model);
    end
    e.write_ram = ram_model(r.write_addr, eb_model);
    e.write_en  = r.write_en && (r.write_addr < 12'o2000);
    return e;
  endfunction

  function automatic word_t expected_word(input logic [1:0] sel);
    word_t w;
    w = '0;
    if (sel == 2'd0 || sel == 2'd2) w[11:9] = eb_model;
    if (sel == 2'd1 || sel == 2'd2) w[14:12] = fb_model;
    return w;
  endfunction

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Wait for ack, drop the strobe and confirm ack is a single pulse
  task automatic finish_transfer();
    do begin
      @(negedge clk);
    end while (wb_ack !== 1'b1);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    check("wb ack pulse width", 64'(0), 64'(wb_ack));
  endtask

  task automatic wb_write(input logic [1:0] sel, input word_t data);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = bank_sel_t'(sel);
    wb_wdata = data;
    finish_transfer();
    case (sel)
      2'd0: eb_model = data[11:9];
      2'd1: fb_model = data[14:12];
      2'd2: begin
        eb_model = data[11:9];
        fb_model = data[14:12];
      end
      default: ;
    endcase
  endtask

  task automatic wb_read(input string name, input logic [1:0] sel);
    word_t data;
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = bank_sel_t'(sel);
    do begin
      @(negedge clk);
    end while (wb_ack !== 1'b1);
    data   = wb_rdata;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    @(negedge clk);
    check("wb ack pulse width", 64'(0), 64'(wb_ack));
    check(name, 64'(expected_word(sel)), 64'(data));
  endtask

  task automatic send_request(input string name, input xlate_req_t r);
    xlate_rsp_t e;
    @(negedge clk);
    req_valid = 1'b1;
    req       = r;
    e         = expected_rsp(r);
    @(negedge clk);
    req_valid = 1'b0;
    check({name, " valid"}, 64'(1), 64'(rsp_valid));
    check(name, 64'(e), 64'(rsp));
  endtask

  task automatic reset_and_idle();
    rst_l = 1'b0;
    repeat (16) begin
      @(negedge clk);
      check("reset rsp_valid", 64'(0), 64'(rsp_valid));
      check("reset wb_ack", 64'(0), 64'(wb_ack));
    end
    rst_l = 1'b1;
    repeat (2) @(negedge clk);
    check("idle rsp_valid", 64'(0), 64'(rsp_valid));
    wb_read("reset BB readback", 2'd2);
  endtask

  task automatic bank_register_port();
    // Each write sets every bit outside its own field
    wb_write(2'd0, 15'h7fff & ~(15'd2 << 9));
    wb_read("EB after EB write", 2'd0);
    wb_read("FB after EB write", 2'd1);
    wb_read("BB after EB write", 2'd2);
    wb_write(2'd1, 15'h7fff & ~(15'd6 << 12));
    wb_read("EB after FB write", 2'd0);
    wb_read("FB after FB write", 2'd1);
    wb_read("BB after FB write", 2'd2);
    wb_write(2'd2, (15'd3 << 12) | (15'd6 << 9) | 15'h01ff);
    wb_read("BB after BB write", 2'd2);
    wb_read("EB after BB write", 2'd0);
    wb_read("FB after BB write", 2'd1);
    // Unmapped select
    wb_write(2'd3, 15'h7fff);
    wb_read("unmapped select readback", 2'd3);
    wb_read("BB after unmapped write", 2'd2);
  endtask

  task automatic fetch_translation();
    xlate_req_t r;
    for (int f = 0; f < 8; f++) begin
      wb_write(2'd1, word_t'(f << 12));
      r = random_request();
      r.fetch_addr = 12'o3777;
      send_request("fetch at 3777", r);
      r.fetch_addr = 12'o4000;
      send_request("fetch at 4000", r);
      for (int k = 0; k < 4; k++) begin
        r = random_request();
        r.fetch_addr = addr_in_range(0, 'o4000);
        send_request("fetch banked", r);
        r.fetch_addr = addr_in_range('o4000, 'o4000);
        send_request("fetch fixed-fixed", r);
      end
    end
  endtask

  task automatic read_translation();
    xlate_req_t r;
    for (int e = 0; e < 8; e++) begin
      wb_write(2'd0, word_t'(e << 9));
      foreach (read_edges[i]) begin
        r = random_request();
        r.read_addr = read_edges[i];
        send_request("read boundary", r);
      end
      for (int k = 0; k < 2; k++) begin
        r = random_request();
        r.read_addr = addr_in_range(0, 'o1400);
        send_request("read fixed RAM", r);
        r.read_addr = addr_in_range('o1400, 'o400);
        send_request("read banked RAM", r);
        r.read_addr = addr_in_range('o2000, 'o6000);
        send_request("read ROM", r);
      end
    end
  endtask

  task automatic write_gating();
    xlate_req_t r;
    foreach (gate_banks[b]) begin
      wb_write(2'd0, word_t'(gate_banks[b]) << 9);
      foreach (write_edges[i]) begin
        r = random_request();
        r.write_addr = write_edges[i];
        r.write_en   = 1'b1;
        send_request("write enabled", r);
        r.write_en   = 1'b0;
        send_request("write disabled", r);
      end
    end
  endtask

  // Back-to-back requests with a BB write issued alongside request write_at
  task automatic stream_burst(input int count, input int write_at, input word_t bb_data);
    xlate_req_t r;
    xlate_rsp_t e;
    logic       wb_busy;
    logic       ack_seen;
    wb_busy  = 1'b0;
    ack_seen = 1'b0;
    for (int i = 0; i <= count; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check("stream valid", 64'(1), 64'(rsp_valid));
        check("stream response", 64'(e), 64'(rsp));
      end
      if (ack_seen) begin
        check("stream ack pulse width", 64'(0), 64'(wb_ack));
        ack_seen = 1'b0;
      end
      if (wb_busy && wb_ack === 1'b1) begin
        // Banks load on the ack edge and apply from the next request
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        eb_model = bb_data[11:9];
        fb_model = bb_data[14:12];
        wb_busy  = 1'b0;
        ack_seen = 1'b1;
      end
      if (i == write_at) begin
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = BANK_BB;
        wb_wdata = bb_data;
        wb_busy  = 1'b1;
      end
      if (i < count) begin
        r         = random_request();
        req_valid = 1'b1;
        req       = r;
        e         = expected_rsp(r);
      end else begin
        req_valid = 1'b0;
      end
    end
    if (wb_busy) begin
      errors++;
      $display("The bank write issued during the stream was never acknowledged");
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
    end
  endtask

  task automatic streaming();
    word_t bb_data;
    wb_write(2'd2, word_t'(next_random()));
    // New values differ in both fields from the current ones
    bb_data        = word_t'(next_random());
    bb_data[11:9]  = ~eb_model;
    bb_data[14:12] = ~fb_model;
    stream_burst(300, 150, bb_data);
    wb_read("BB after stream write", 2'd2);
  endtask

  initial begin
    rand_state  = 32'd47676;
    errors      = 0;
    checks      = 0;
    eb_model    = '0;
    fb_model    = '0;
    rst_l       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = BANK_EB;
    wb_wdata    = '0;
    req_valid   = 1'b0;
    req         = '0;

    reset_and_idle();
    bank_register_port();
    fetch_translation();
    read_translation();
    write_gating();
    streaming();

    @(negedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* agc_bank_map.f */
agc_bank_map_pkg.sv
bank_regs_wb.sv
rom_bank_map.sv
ram_bank_map.sv
access_resolve.sv
agc_bank_map.sv
tb_agc_bank_map.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing
TOP       = tb_agc_bank_map
FILELIST  = agc_bank_map.f

SOURCES = $(wildcard *.sv)
BIN     = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
